//--- Makefile
# Verilator build and run of the check-node regression
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ldpc_cnode \
		-f list.f --Mdir obj_dir -o tb_ldpc_cnode
	@out="$$(./obj_dir/tb_ldpc_cnode)"; echo "$$out"; \
		echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- ldpc_cnode_consts.svh
// sizing and normalisation constants for the check-node unit
// included by both packages and by the modules that size ports with them
`ifndef LDPC_CNODE_CONSTS_SVH
`define LDPC_CNODE_CONSTS_SVH

// --------------------------------------------------
// lanes and widths
// --------------------------------------------------
`define LDPC_ZC            4   // lanes per beat
`define LDPC_NODE_W        5   // sign + 4 bit magnitude
`define LDPC_SHIFT_W       2   // cyclic shift amount
`define LDPC_ROW_MAX       8   // longest row, beats
`define LDPC_IDX_W         3   // beat index inside a row
`define LDPC_FIFO_DEPTH_W  4   // room for two rows of signs
`define LDPC_ADDR_W        8   // output beat address

// --------------------------------------------------
// min-sum normalisation: mag * 7/8, then minus 1
// --------------------------------------------------
`define LDPC_NORM_FACTOR   7   // eighths
`define LDPC_NORM_OFFSET   1   // saturates at 0

`endif

//--- ldpc_cnode_in_side.sv
// input side: LLR/vnode select, left rotation by beat shift
// strobes and context follow the data through both stages
`timescale 1ns/100ps
`default_nettype none

module ldpc_cnode_in_side (
  input  wire logic                       iclk,
  input  wire logic                       ireset,
  input  wire logic                       ival,
  input  wire logic                       iload_iter,
  input  wire ldpc_ctrl_pkg::strb_t       istrb,
  input  wire ldpc_ctrl_pkg::cnode_ctx_t  icnode_ctx,
  input  wire ldpc_node_pkg::znode_t      illr,
  input  wire ldpc_node_pkg::znode_t      ivnode,
  output logic                            rot_val,
  output ldpc_node_pkg::znode_t           rot_node,
  output ldpc_ctrl_pkg::strb_t            rot_strb,
  output ldpc_ctrl_pkg::cnode_ctx_t       rot_ctx
);
  import ldpc_node_pkg::*;
  import ldpc_ctrl_pkg::*;

  logic                  sel_val;   // stage 1 strobe
  znode_t                sel_node;  // stage 1 selected beat
  strb_t      [1:0]      strb_d;    // [0] select stage, [1] rotator stage
  cnode_ctx_t [1:0]      ctx_d;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      sel_val <= 1'b0;
      strb_d  <= '0;
    end else begin
      sel_val <= ival;
      strb_d  <= {strb_d[0], istrb};
    end
  end

  always_ff @(posedge iclk) begin
    sel_node <= iload_iter ? illr : ivnode;  // channel LLR on load iteration
    ctx_d    <= {ctx_d[0], icnode_ctx};
  end

  ldpc_cnode_rotator #(.pR_SHIFT(1'b0)) in_rot_i (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (sel_val),
    .idat   (sel_node),
    .ishift (ctx_d[0].shift),  // shift of the beat in the select stage
    .oval   (rot_val),
    .odat   (rot_node)
  );

  assign rot_strb = strb_d[1];
  assign rot_ctx  = ctx_d[1];

endmodule

`default_nettype wire

//--- ldpc_cnode_min_sort.sv
// per-lane min1/min2/index/sign-parity search over one row
// result held from sort_val until the next row ends, plus decode-fail flag
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_cnode_consts.svh"

module ldpc_cnode_min_sort (
  input  wire logic                                    iclk,
  input  wire logic                                    ireset,
  input  wire logic                                    istart,
  input  wire logic                                    rot_val,
  input  wire ldpc_node_pkg::znode_t                   rot_node,
  input  wire ldpc_ctrl_pkg::strb_t                    rot_strb,
  output logic                                         sort_val,
  output ldpc_node_pkg::mag_t [`LDPC_ZC-1:0]           min1,
  output ldpc_node_pkg::mag_t [`LDPC_ZC-1:0]           min2,
  output ldpc_ctrl_pkg::idx_t [`LDPC_ZC-1:0]           min_idx,
  output ldpc_node_pkg::zbit_t                         sign_par,
  output logic                                         odecfail
);
  import ldpc_node_pkg::*;
  import ldpc_ctrl_pkg::*;

  localparam int cMAG_W = `LDPC_NODE_W - 1;

  idx_t                    beat_cnt;  // index of the incoming beat when not sof
  mag_t  [`LDPC_ZC-1:0]    in_mag;
  zbit_t                   in_sign;
  mag_t  [`LDPC_ZC-1:0]    m1_r;      // running search state
  mag_t  [`LDPC_ZC-1:0]    m2_r;
  idx_t  [`LDPC_ZC-1:0]    idx_r;
  zbit_t                   par_r;
  mag_t  [`LDPC_ZC-1:0]    m1_nxt;
  mag_t  [`LDPC_ZC-1:0]    m2_nxt;
  idx_t  [`LDPC_ZC-1:0]    idx_nxt;
  zbit_t                   par_nxt;

  // --------------------------------------------------
  // search step
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < `LDPC_ZC; i++) begin
      in_mag[i]  = rot_node[i][cMAG_W-1:0];
      in_sign[i] = rot_node[i][cMAG_W];
      if (rot_strb.sof) begin  // restart, first beat is min1
        m1_nxt[i]  = in_mag[i];
        m2_nxt[i]  = '1;
        idx_nxt[i] = '0;
        par_nxt[i] = in_sign[i];
      end else begin
        m1_nxt[i]  = m1_r[i];
        m2_nxt[i]  = m2_r[i];
        idx_nxt[i] = idx_r[i];
        par_nxt[i] = par_r[i] ^ in_sign[i];
        if (in_mag[i] < m1_r[i]) begin  // strict, first beat keeps min1 on ties
          m2_nxt[i]  = m1_r[i];
          m1_nxt[i]  = in_mag[i];
          idx_nxt[i] = beat_cnt;
        end else if (in_mag[i] < m2_r[i]) begin
          m2_nxt[i]  = in_mag[i];
        end
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (rot_val) begin
      m1_r  <= m1_nxt;
      m2_r  <= m2_nxt;
      idx_r <= idx_nxt;
      par_r <= par_nxt;
    end
    if (rot_val && rot_strb.eof) begin  // latch row result
      min1     <= m1_nxt;
      min2     <= m2_nxt;
      min_idx  <= idx_nxt;
      sign_par <= par_nxt;
    end
  end

  // --------------------------------------------------
  // control, decode fail
  // --------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      beat_cnt <= '0;
      sort_val <= 1'b0;
      odecfail <= 1'b0;
    end else begin
      sort_val <= rot_val & rot_strb.eof;
      if (rot_val) beat_cnt <= rot_strb.sof ? idx_t'(1) : beat_cnt + 1'b1;
      if (istart)                     odecfail <= 1'b0;
      else if (sort_val && |sign_par) odecfail <= 1'b1;  // odd hard-decision parity
    end
  end

  // sof only ever rides on a valid beat out of the input pipeline
  a_sof_val : assert property (@(posedge iclk) disable iff (ireset)
    rot_strb.sof |-> rot_val);

endmodule

`default_nettype wire

//--- ldpc_cnode_out_side.sv
// output side: right rotation back to natural lane order, output beat address
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_cnode_consts.svh"

module ldpc_cnode_out_side (
  input  wire logic                       iclk,
  input  wire logic                       ireset,
  input  wire logic                       istart,
  input  wire logic                       rst_val,
  input  wire ldpc_node_pkg::znode_t      rst_node,
  input  wire ldpc_ctrl_pkg::cnode_ctx_t  rst_ctx,
  output logic                            ocnode_val,
  output ldpc_node_pkg::znode_t           ocnode,
  output logic [`LDPC_ADDR_W-1:0]         ocnode_addr
);

  ldpc_cnode_rotator #(.pR_SHIFT(1'b1)) out_rot_i (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (rst_val),
    .idat   (rst_node),
    .ishift (rst_ctx.shift),  // same shift as on the way in
    .oval   (ocnode_val),
    .odat   (ocnode)
  );

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset)          ocnode_addr <= '0;
    else if (istart)     ocnode_addr <= '0;  // new iteration
    else if (ocnode_val) ocnode_addr <= ocnode_addr + 1'b1;
  end

endmodule

`default_nettype wire

//--- ldpc_cnode_restore.sv
// sign/context FIFO and restore FSM, rebuilds one normalised message per beat
// emits the row in input order starting the cycle after sort_val
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_cnode_consts.svh"

module ldpc_cnode_restore (
  input  wire logic                                    iclk,
  input  wire logic                                    ireset,
  input  wire logic                                    rot_val,
  input  wire ldpc_node_pkg::znode_t                   rot_node,
  input  wire ldpc_ctrl_pkg::cnode_ctx_t               rot_ctx,
  input  wire logic                                    sort_val,
  input  wire ldpc_node_pkg::mag_t [`LDPC_ZC-1:0]      min1,
  input  wire ldpc_node_pkg::mag_t [`LDPC_ZC-1:0]      min2,
  input  wire ldpc_ctrl_pkg::idx_t [`LDPC_ZC-1:0]      min_idx,
  input  wire ldpc_node_pkg::zbit_t                    sign_par,
  output logic                                         rst_val,
  output ldpc_node_pkg::znode_t                        rst_node,
  output ldpc_ctrl_pkg::cnode_ctx_t                    rst_ctx,
  output logic                                         obusy
);
  import ldpc_node_pkg::*;
  import ldpc_ctrl_pkg::*;

  localparam int cDEPTH  = 1 << `LDPC_FIFO_DEPTH_W;
  localparam int cMAG_W  = `LDPC_NODE_W - 1;
  localparam int cPROD_W = cMAG_W + 3;  // room for factor up to 7

  zbit_t                          fifo_sign [cDEPTH];
  cnode_ctx_t                     fifo_ctx  [cDEPTH];
  logic [`LDPC_FIFO_DEPTH_W-1:0]  wptr;
  logic [`LDPC_FIFO_DEPTH_W-1:0]  rptr;
  logic [`LDPC_FIFO_DEPTH_W:0]    fifo_cnt;
  logic                           fifo_rd;
  zbit_t                          wr_sign;

  restore_state_e                 state;
  idx_t                           bidx;      // next beat index while emitting
  idx_t                           last_idx;  // index of row's last beat
  logic [`LDPC_IDX_W:0]           wr_cnt;    // beats written for the open row
  logic [`LDPC_IDX_W:0]           len_m1;
  idx_t                           cur_idx;
  znode_t                         node_nxt;

  // mag * 7/8 rounded down, then minus offset with floor at 0
  function automatic mag_t norm_mag(input mag_t m);
    logic [cPROD_W-1:0] prod;
    mag_t               scaled;
    prod   = {3'b000, m} * cPROD_W'(`LDPC_NORM_FACTOR);
    scaled = prod[cPROD_W-1:3];
    return (scaled > mag_t'(`LDPC_NORM_OFFSET)) ? scaled - mag_t'(`LDPC_NORM_OFFSET) : '0;
  endfunction

  // --------------------------------------------------
  // rebuild
  // --------------------------------------------------
  assign fifo_rd = sort_val | (state == RST_EMIT);
  assign len_m1  = wr_cnt - 1'b1;

  always_comb begin
    cur_idx = sort_val ? '0 : bidx;  // beat 0 goes out on sort_val itself
    for (int i = 0; i < `LDPC_ZC; i++) begin
      wr_sign[i]              = rot_node[i][cMAG_W];
      node_nxt[i][cMAG_W]     = sign_par[i] ^ fifo_sign[rptr][i];  // exclude own sign
      node_nxt[i][cMAG_W-1:0] = norm_mag((cur_idx == min_idx[i]) ? min2[i] : min1[i]);
    end
  end

  always_ff @(posedge iclk) begin
    if (rot_val) begin
      fifo_sign[wptr] <= wr_sign;
      fifo_ctx[wptr]  <= rot_ctx;
    end
    if (fifo_rd) begin
      rst_node <= node_nxt;
      rst_ctx  <= fifo_ctx[rptr];
    end
  end

  // --------------------------------------------------
  // pointers, row length, FSM
  // --------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wptr     <= '0;
      rptr     <= '0;
      fifo_cnt <= '0;
      wr_cnt   <= '0;
      state    <= RST_IDLE;
      bidx     <= '0;
      last_idx <= '0;
      rst_val  <= 1'b0;
      obusy    <= 1'b0;
    end else begin
      rst_val <= fifo_rd;
      obusy   <= (fifo_cnt != '0);  // one cycle behind FIFO level
      if (rot_val) wptr <= wptr + 1'b1;
      if (fifo_rd) rptr <= rptr + 1'b1;
      case ({rot_val, fifo_rd})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
      // eof beat was counted the cycle before sort_val
      if (sort_val) wr_cnt <= {{`LDPC_IDX_W{1'b0}}, rot_val};
      else if (rot_val) wr_cnt <= wr_cnt + 1'b1;
      case (state)
        RST_IDLE: if (sort_val) begin
          bidx     <= idx_t'(1);
          last_idx <= len_m1[`LDPC_IDX_W-1:0];
          if (len_m1 != '0) state <= RST_EMIT;
        end
        RST_EMIT: begin
          bidx <= bidx + 1'b1;
          if (bidx == last_idx) state <= RST_IDLE;  // last beat read now
        end
        default: state <= RST_IDLE;
      endcase
    end
  end

  a_fifo_ovf : assert property (@(posedge iclk) disable iff (ireset)
    (rot_val && !fifo_rd) |-> (fifo_cnt < (`LDPC_FIFO_DEPTH_W + 1)'(cDEPTH)));

  // next row must not finish its search while this row still drains
  a_no_overlap : assert property (@(posedge iclk) disable iff (ireset)
    sort_val |-> (state == RST_IDLE));

endmodule

`default_nettype wire

//--- ldpc_cnode_rotator.sv
// one-stage registered cyclic lane rotator
// pR_SHIFT = 0 rotates left, 1 rotates right and undoes a left rotation
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_cnode_consts.svh"

module ldpc_cnode_rotator #(
  parameter bit pR_SHIFT = 1'b0
) (
  input  wire logic                      iclk,
  input  wire logic                      ireset,
  input  wire logic                      ival,
  input  wire ldpc_node_pkg::znode_t     idat,
  input  wire logic [`LDPC_SHIFT_W-1:0]  ishift,
  output logic                           oval,
  output ldpc_node_pkg::znode_t          odat
);
  import ldpc_node_pkg::*;

  localparam int cZC = `LDPC_ZC;

  znode_t rot;  // combinational rotated beat

  always_comb begin
    for (int i = 0; i < cZC; i++) begin
      if (pR_SHIFT) rot[i] = idat[(i + cZC - int'(ishift)) % cZC];  // lane i <- i-s
      else          rot[i] = idat[(i + int'(ishift)) % cZC];        // lane i <- i+s
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) oval <= 1'b0;
    else        oval <= ival;
  end

  always_ff @(posedge iclk) begin
    odat <= rot;  // payload, no reset
  end

endmodule

`default_nettype wire

//--- ldpc_cnode_top.sv
// check-node unit top: input side, min search, restore, output side
// row output starts 5 cycles after its eof beat
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_cnode_consts.svh"

module ldpc_cnode_top (
  input  wire logic                       iclk,
  input  wire logic                       ireset,
  input  wire logic                       istart,
  input  wire logic                       iload_iter,
  input  wire logic                       ival,
  input  wire ldpc_ctrl_pkg::strb_t       istrb,
  input  wire ldpc_ctrl_pkg::cnode_ctx_t  icnode_ctx,
  input  wire ldpc_node_pkg::znode_t      illr,
  input  wire ldpc_node_pkg::znode_t      ivnode,
  output logic                            ocnode_val,
  output logic [`LDPC_ADDR_W-1:0]         ocnode_addr,
  output ldpc_node_pkg::znode_t           ocnode,
  output logic                            odecfail,
  output logic                            obusy
);
  import ldpc_node_pkg::*;
  import ldpc_ctrl_pkg::*;

  // input side -> sort, restore
  logic                    rot_val;
  znode_t                  rot_node;
  strb_t                   rot_strb;
  cnode_ctx_t              rot_ctx;
  // sort -> restore
  logic                    sort_val;
  mag_t  [`LDPC_ZC-1:0]    min1;
  mag_t  [`LDPC_ZC-1:0]    min2;
  idx_t  [`LDPC_ZC-1:0]    min_idx;
  zbit_t                   sign_par;
  // restore -> output side
  logic                    rst_val;
  znode_t                  rst_node;
  cnode_ctx_t              rst_ctx;

  ldpc_cnode_in_side in_side_i (
    .iclk, .ireset, .ival, .iload_iter, .istrb, .icnode_ctx, .illr, .ivnode,
    .rot_val, .rot_node, .rot_strb, .rot_ctx
  );

  ldpc_cnode_min_sort min_sort_i (
    .iclk, .ireset, .istart, .rot_val, .rot_node, .rot_strb,
    .sort_val, .min1, .min2, .min_idx, .sign_par, .odecfail
  );

  ldpc_cnode_restore restore_i (
    .iclk, .ireset, .rot_val, .rot_node, .rot_ctx,
    .sort_val, .min1, .min2, .min_idx, .sign_par,
    .rst_val, .rst_node, .rst_ctx, .obusy
  );

  ldpc_cnode_out_side out_side_i (
    .iclk, .ireset, .istart, .rst_val, .rst_node, .rst_ctx,
    .ocnode_val, .ocnode, .ocnode_addr
  );

endmodule

`default_nettype wire

//--- ldpc_ctrl_pkg.sv
// control types: row strobes, beat context, beat index, restore FSM states
`default_nettype none

`include "ldpc_cnode_consts.svh"

package ldpc_ctrl_pkg;

  typedef struct packed {
    logic sof;  // first beat of row
    logic eof;  // last beat of row
  } strb_t;

  typedef struct packed {
    logic [`LDPC_SHIFT_W-1:0] shift;  // cyclic lane shift of this beat
  } cnode_ctx_t;

  typedef logic [`LDPC_IDX_W-1:0] idx_t;

  typedef enum logic {RST_IDLE = 1'b0, RST_EMIT = 1'b1} restore_state_e;

endpackage

`default_nettype wire

//--- ldpc_node_pkg.sv
// data path types for check-node messages
// message is sign-magnitude, sign in the top bit
`default_nettype none

`include "ldpc_cnode_consts.svh"

package ldpc_node_pkg;

  // one lane message
  typedef logic [`LDPC_NODE_W-1:0] node_t;

  // magnitude only, sign stripped
  typedef logic [`LDPC_NODE_W-2:0] mag_t;

  // full beat, one message per lane
  typedef node_t [`LDPC_ZC-1:0] znode_t;

  // one flag per lane, used for signs and parity
  typedef logic [`LDPC_ZC-1:0] zbit_t;

endpackage

`default_nettype wire

//--- list.f
+incdir+.
ldpc_node_pkg.sv
ldpc_ctrl_pkg.sv
ldpc_cnode_rotator.sv
ldpc_cnode_in_side.sv
ldpc_cnode_min_sort.sv
ldpc_cnode_restore.sv
ldpc_cnode_out_side.sv
ldpc_cnode_top.sv
tb_ldpc_cnode.sv

//--- tb_ldpc_cnode.sv
// testbench for the check-node unit with random rows and a cycle-indexed reference model
// concurrent assertions compare every DUT output with the model each clock
`timescale 1ns/100ps
`default_nettype none

`include "ldpc_cnode_consts.svh"

module tb_ldpc_cnode;
  import ldpc_node_pkg::*;
  import ldpc_ctrl_pkg::*;

  localparam int cZC    = `LDPC_ZC;
  localparam int cMAG_W = `LDPC_NODE_W - 1;
  localparam int cROWS  = 6;                    // rows per iteration
  localparam int cGAP   = `LDPC_ROW_MAX + 6;    // idle beats so rows never overlap
  localparam int cLIMIT = 64 + 3 * cROWS * (`LDPC_ROW_MAX + 1 + cGAP);
  localparam int cSLOTS = cLIMIT + 32;

  logic                     iclk;
  logic                     ireset;
  logic                     istart;
  logic                     iload_iter;
  logic                     ival;
  strb_t                    istrb;
  cnode_ctx_t               icnode_ctx;
  znode_t                   illr;
  znode_t                   ivnode;
  logic                     ocnode_val;
  logic [`LDPC_ADDR_W-1:0]  ocnode_addr;
  znode_t                   ocnode;
  logic                     odecfail;
  logic                     obusy;

  integer seed = 32'hcae5;
  int     cyc = 0;          // rising edges so far
  int     errors = 0;
  int     err_mark = 0;
  int     ntests = 0;
  int     nfailed = 0;
  int     out_cnt = 0;      // output beats since istart
  int     busy_lvl = 0;

  // expected outputs indexed by the edge that registers them
  bit                       out_val  [cSLOTS];
  znode_t                   out_node [cSLOTS];
  logic [`LDPC_ADDR_W-1:0]  out_addr [cSLOTS];
  bit                       fail_set [cSLOTS];
  bit                       fail_clr [cSLOTS];
  int                       busy_inc [cSLOTS];
  int                       busy_dec [cSLOTS];

  logic                     exp_val = 1'b0;
  znode_t                   exp_node = '0;
  logic [`LDPC_ADDR_W-1:0]  exp_addr = '0;
  logic                     exp_busy = 1'b0;
  logic                     exp_fail = 1'b0;

  ldpc_cnode_top ldpc_cnode_top_i (.*);

  always #20 iclk = ~iclk;  // 40 ns period

  always @(posedge iclk) begin
    cyc <= cyc + 1;
    if (cyc == cLIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", cLIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  // model outputs for the coming edge
  always @(negedge iclk) begin
    busy_lvl = busy_lvl + busy_inc[cyc] - busy_dec[cyc];
    exp_busy = (busy_lvl != 0);
    if (fail_set[cyc]) exp_fail = 1'b1;
    if (fail_clr[cyc]) exp_fail = 1'b0;  // istart wins
    exp_val  = out_val[cyc];
    exp_node = out_node[cyc];
    exp_addr = out_addr[cyc];
  end

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------
  task automatic flag_mismatch(input string what, input logic [31:0] exp, input logic [31:0] got);
    errors++;
    $display("[ERROR] %s: expected %h, got %h (cycle %0d)", what, exp, got, cyc);
  endtask

  task automatic next_cycle();
    @(posedge iclk);
    #2;  // drive after the edge
  endtask

  function automatic znode_t rot_left(input znode_t d, input int s);
    znode_t r;
    for (int i = 0; i < cZC; i++) r[i] = d[(i + s) % cZC];  // lane i takes lane i+s
    return r;
  endfunction

  function automatic znode_t rot_right(input znode_t d, input int s);
    znode_t r;
    for (int i = 0; i < cZC; i++) r[i] = d[(i + cZC - s) % cZC];
    return r;
  endfunction

  // times 7/8 rounded down then minus 1 floored at 0
  function automatic mag_t norm(input mag_t m);
    int scaled;
    scaled = (int'(m) * `LDPC_NORM_FACTOR) / 8;
    return (scaled > `LDPC_NORM_OFFSET) ? mag_t'(scaled - `LDPC_NORM_OFFSET) : '0;
  endfunction

  function automatic int rand_len();
    return 2 + ($unsigned($random(seed)) % (`LDPC_ROW_MAX - 1));
  endfunction

  task automatic start_iteration(input logic load);
    next_cycle();
    istart     = 1'b1;
    iload_iter = load;
    fail_clr[cyc + 1] = 1'b1;  // flag cleared by the capturing edge
    out_cnt    = 0;
    next_cycle();
    istart     = 1'b0;
  endtask

  // mode 0 random parity, 1 even in every lane, 2 odd in lane 0
  task automatic send_row(input int len, input int mode);
    znode_t msg [`LDPC_ROW_MAX];
    znode_t rl  [`LDPC_ROW_MAX];  // rotated view
    znode_t ro  [`LDPC_ROW_MAX];  // rebuilt beats in rotated view
    int     sh  [`LDPC_ROW_MAX];
    mag_t   m1;
    mag_t   m2;
    int     idx;
    logic   par;
    logic   odd;
    int     ke;
    odd = 1'b0;
    for (int b = 0; b < len; b++) begin
      msg[b] = znode_t'($random(seed));
      sh[b]  = $unsigned($random(seed)) % cZC;
      rl[b]  = rot_left(msg[b], sh[b]);
    end
    for (int i = 0; i < cZC; i++) begin
      par = 1'b0;
      for (int b = 0; b < len; b++) par ^= rl[b][i][cMAG_W];
      if ((mode == 1 && par) || (mode == 2 && i == 0 && !par)) begin
        rl[len-1][i][cMAG_W] = ~rl[len-1][i][cMAG_W];  // fix parity on last beat
        par = ~par;
      end
      odd |= par;
      m1  = rl[0][i][cMAG_W-1:0];
      idx = 0;
      for (int b = 1; b < len; b++) begin
        if (rl[b][i][cMAG_W-1:0] < m1) begin  // first beat keeps ties
          m1  = rl[b][i][cMAG_W-1:0];
          idx = b;
        end
      end
      m2 = '1;
      for (int b = 0; b < len; b++) begin
        if (b != idx && rl[b][i][cMAG_W-1:0] < m2) m2 = rl[b][i][cMAG_W-1:0];
      end
      for (int b = 0; b < len; b++) begin
        ro[b][i] = {par ^ rl[b][i][cMAG_W], norm((b == idx) ? m2 : m1)};
      end
    end
    msg[len-1] = rot_right(rl[len-1], sh[len-1]);
    for (int b = 0; b < len; b++) begin
      next_cycle();
      ival             = 1'b1;
      istrb.sof        = (b == 0);
      istrb.eof        = (b == len - 1);
      icnode_ctx.shift = sh[b][`LDPC_SHIFT_W-1:0];
      illr             = iload_iter ? msg[b] : znode_t'($random(seed));  // other source is noise
      ivnode           = iload_iter ? znode_t'($random(seed)) : msg[b];
      busy_inc[cyc + 4]++;  // beat reaches the FIFO
    end
    ke = cyc;
    for (int b = 0; b < len; b++) begin
      out_val[ke + 5 + b]  = 1'b1;
      out_node[ke + 5 + b] = rot_right(ro[b], sh[b]);
      out_addr[ke + 5 + b] = out_cnt[`LDPC_ADDR_W-1:0];
      busy_dec[ke + 5 + b]++;
      out_cnt++;
    end
    if (odd) fail_set[ke + 4] = 1'b1;
    next_cycle();
    ival  = 1'b0;
    istrb = '0;
    repeat (cGAP) next_cycle();
  endtask

  task automatic end_test(input string name);
    ntests++;
    if (errors != err_mark) nfailed++;
    $display("test %0d %s: %0d error(s)", ntests, name, errors - err_mark);
    err_mark = errors;
  endtask

  // ------------------------------------------------
  // checks
  // ------------------------------------------------
  a_reset_idle : assert property (@(posedge iclk)
      (cyc > 0) && (ireset || $fell(ireset)) |->
      (!ocnode_val && !obusy && !odecfail && ocnode_addr == '0))
    else flag_mismatch("ocnode_val/obusy/odecfail/ocnode_addr", 0,
                       {$sampled(ocnode_val), $sampled(obusy), $sampled(odecfail),
                        $sampled(ocnode_addr)});

  a_val : assert property (@(posedge iclk) disable iff (ireset) ocnode_val == exp_val)
    else flag_mismatch("ocnode_val", $sampled(exp_val), $sampled(ocnode_val));

  a_node : assert property (@(posedge iclk) disable iff (ireset) exp_val |-> ocnode == exp_node)
    else flag_mismatch("ocnode", $sampled(exp_node), $sampled(ocnode));

  a_addr : assert property (@(posedge iclk) disable iff (ireset)
      exp_val |-> ocnode_addr == exp_addr)
    else flag_mismatch("ocnode_addr", $sampled(exp_addr), $sampled(ocnode_addr));

  a_addr_clr : assert property (@(posedge iclk) disable iff (ireset)
      istart |=> ocnode_addr == '0)
    else flag_mismatch("ocnode_addr", 0, $sampled(ocnode_addr));

  a_busy : assert property (@(posedge iclk) disable iff (ireset) obusy == exp_busy)
    else flag_mismatch("obusy", $sampled(exp_busy), $sampled(obusy));

  a_fail : assert property (@(posedge iclk) disable iff (ireset) odecfail == exp_fail)
    else flag_mismatch("odecfail", $sampled(exp_fail), $sampled(odecfail));

  // ------------------------------------------------
  // stimulus
  // ------------------------------------------------
  initial begin
    iclk       = 1'b0;
    ireset     = 1'b1;
    istart     = 1'b0;
    iload_iter = 1'b0;
    ival       = 1'b0;
    istrb      = '0;
    icnode_ctx = '0;
    illr       = '0;
    ivnode     = '0;
    repeat (8) @(posedge iclk);
    #2 ireset = 1'b0;
    repeat (4) next_cycle();
    end_test("reset");
    start_iteration(1'b1);  // load iteration with LLR input
    repeat (cROWS) send_row(rand_len(), 0);
    end_test("llr rows");
    start_iteration(1'b0);  // vnode messages in
    repeat (cROWS) send_row(rand_len(), 0);
    end_test("vnode rows");
    start_iteration(1'b0);
    repeat (cROWS - 1) send_row(rand_len(), 1);  // flag must stay low
    send_row(rand_len(), 2);
    start_iteration(1'b1);  // clears the flag
    repeat (4) next_cycle();
    end_test("decode fail");
    $display("tests %0d, failed %0d, errors %0d", ntests, nfailed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
